/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide by the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module ptw_tb -o ptw_sim \
    > build.log 2>&1 \
    && ./obj_dir/ptw_sim > sim.log 2>&1
grep -q "All tests passed!" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL, see build.log and sim.log"; exit 1; }

/* sim.f */
src/ptw_pkg.sv
src/ptw_walk_ctx.sv
src/ptw_pte_check.sv
src/ptw_fsm.sv
src/ptw_top.sv
verification/ptw_assert.sv
verification/ptw_tb.sv

/* src/ptw_fsm.sv */
// page walk FSM with miss arbitration, read requests, update and error pulses, flush
`timescale 1ns/1ps

module ptw_fsm (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  enable_translation_i,
    input  logic                  en_ld_st_translation_i,
    input  logic                  itlb_access_i,
    input  logic                  itlb_hit_i,
    input  logic                  dtlb_access_i,
    input  logic                  dtlb_hit_i,
    input  logic                  mem_gnt_i,
    input  logic                  rsp_valid_i,
    input  ptw_pkg::pte_verdict_e verdict_i,
    input  logic                  is_instr_i,
    output ptw_pkg::ctx_ctl_t     ctl_o,
    output logic                  mem_req_o,
    output logic                  itlb_update_valid_o,
    output logic                  dtlb_update_valid_o,
    output logic                  ptw_active_o,
    output logic                  ptw_error_o
);

    ptw_pkg::walk_state_e state_q, state_d;

    logic dtlb_miss;
    logic itlb_miss;
    // good leaf seen this cycle
    logic leaf_hit;

    // data side wins, fetch miss only counts without a data access
    assign dtlb_miss = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;
    assign itlb_miss = enable_translation_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;

    always_comb begin
        state_d  = state_q;
        ctl_o    = '0;
        leaf_hit = 1'b0;

        case (state_q)
            ptw_pkg::IDLE: begin
                if (dtlb_miss || itlb_miss) begin
                    ctl_o.start       = 1'b1;
                    ctl_o.start_instr = !dtlb_miss;
                    state_d           = ptw_pkg::WAIT_GRANT;
                end
            end
            ptw_pkg::WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = ptw_pkg::PTE_LOOKUP;
                end
            end
            ptw_pkg::PTE_LOOKUP: begin
                if (rsp_valid_i) begin
                    ctl_o.note_pte = 1'b1;
                    case (verdict_i)
                        ptw_pkg::VERDICT_LEAF: begin
                            leaf_hit = 1'b1;
                            state_d  = ptw_pkg::IDLE;
                        end
                        ptw_pkg::VERDICT_NEXT: begin
                            ctl_o.descend = 1'b1;
                            state_d       = ptw_pkg::WAIT_GRANT;
                        end
                        default: state_d = ptw_pkg::PROPAGATE_ERROR;
                    endcase
                end
            end
            // error pulse lasts this one cycle
            ptw_pkg::PROPAGATE_ERROR: state_d = ptw_pkg::IDLE;
            // drain the response owed by a flushed walk
            ptw_pkg::WAIT_RVALID: begin
                if (rsp_valid_i) begin
                    state_d = ptw_pkg::IDLE;
                end
            end
            default: state_d = ptw_pkg::IDLE;
        endcase

        // ----------------------------------------
        // flush
        // ----------------------------------------
        if (flush_i) begin
            ctl_o    = '0;
            leaf_hit = 1'b0;
            // a granted request still owes one rvalid
            if (((state_q inside {ptw_pkg::PTE_LOOKUP, ptw_pkg::WAIT_RVALID}) && !rsp_valid_i)
                || ((state_q == ptw_pkg::WAIT_GRANT) && mem_gnt_i)) begin
                state_d = ptw_pkg::WAIT_RVALID;
            end else begin
                state_d = ptw_pkg::IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ptw_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Moore outputs, the update pulse alone follows the verdict directly
    assign mem_req_o           = (state_q == ptw_pkg::WAIT_GRANT);
    assign ptw_error_o         = (state_q == ptw_pkg::PROPAGATE_ERROR);
    assign ptw_active_o        = (state_q != ptw_pkg::IDLE);
    assign itlb_update_valid_o = leaf_hit & is_instr_i;
    assign dtlb_update_valid_o = leaf_hit & ~is_instr_i;

endmodule

/* src/ptw_pkg.sv */
// Sv39 widths, page table entry, TLB entry, read port and control structs, walk enums
package ptw_pkg;

    // ----------------------------------------
    // Sv39 geometry
    // ----------------------------------------
    localparam int VLEN          = 39;
    localparam int PLEN          = 56;
    localparam int PPNW          = 44;
    localparam int ASIDW         = 16;
    localparam int VPNW          = 27;
    // one VPN slice per table level
    localparam int LVL_BITS      = 9;
    // 8-byte entries
    localparam int PTE_BYTES_LOG = 3;

    typedef logic [VLEN-1:0]  vaddr_t;
    typedef logic [PLEN-1:0]  paddr_t;
    typedef logic [PPNW-1:0]  ppn_t;
    typedef logic [ASIDW-1:0] asid_t;
    typedef logic [VPNW-1:0]  vpn_t;

    // ----------------------------------------
    // page table entry, msb first
    // ----------------------------------------
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // entry handed to the ITLB or DTLB on a good leaf
    typedef struct packed {
        vpn_t  vpn;
        asid_t asid;
        logic  is_1g;
        logic  is_2m;
        pte_t  content;
    } tlb_entry_t;

    // read port, walker side
    typedef struct packed {
        logic   req;
        paddr_t addr;
    } mem_req_t;

    // read port, memory side
    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [63:0] rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {LVL1, LVL2, LVL3} walk_lvl_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } walk_state_e;

    typedef enum logic [1:0] {VERDICT_LEAF, VERDICT_NEXT, VERDICT_FAULT} pte_verdict_e;

    // commands from the walk FSM to the context registers
    typedef struct packed {
        logic start;
        logic start_instr;
        logic descend;
        logic note_pte;
    } ctx_ctl_t;

endpackage

/* src/ptw_pte_check.sv */
// response register and page table entry verdict logic
`timescale 1ns/1ps

module ptw_pte_check (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  ptw_pkg::mem_rsp_t     mem_rsp_i,
    input  ptw_pkg::walk_lvl_e    lvl_i,
    input  logic                  is_instr_i,
    input  logic                  mxr_i,
    input  logic                  lsu_is_store_i,
    output logic                  rsp_valid_o,
    output ptw_pkg::pte_t         pte_o,
    output ptw_pkg::pte_verdict_e verdict_o
);

    logic        rvalid_q;
    logic [63:0] rdata_q;

    logic is_leaf;
    logic perm_fault;
    logic misaligned;

    // ----------------------------------------
    // response register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_rsp_i.rvalid;
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= mem_rsp_i.rdata;
    end

    assign rsp_valid_o = rvalid_q;
    assign pte_o       = ptw_pkg::pte_t'(rdata_q);

    // ----------------------------------------
    // verdict
    // ----------------------------------------
    // r or x marks a leaf, otherwise a pointer
    assign is_leaf = pte_o.r | pte_o.x;

    always_comb begin
        if (is_instr_i) begin
            // fetch needs execute and accessed
            perm_fault = !pte_o.x || !pte_o.a;
        end else begin
            // loads need r, or x with MXR
            perm_fault = !pte_o.a || !(pte_o.r || (pte_o.x && mxr_i));
            // stores also need w and a set dirty bit
            if (lsu_is_store_i && (!pte_o.w || !pte_o.d)) begin
                perm_fault = 1'b1;
            end
        end
    end

    // superpage PPN must be aligned to the page size
    always_comb begin
        case (lvl_i)
            ptw_pkg::LVL1: misaligned = (pte_o.ppn[2*ptw_pkg::LVL_BITS-1:0] != '0);
            ptw_pkg::LVL2: misaligned = (pte_o.ppn[ptw_pkg::LVL_BITS-1:0] != '0);
            default:       misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (!pte_o.v || (!pte_o.r && pte_o.w)) begin
            // invalid, or the reserved write-without-read
            verdict_o = ptw_pkg::VERDICT_FAULT;
        end else if (is_leaf) begin
            verdict_o = (perm_fault || misaligned) ? ptw_pkg::VERDICT_FAULT
                                                   : ptw_pkg::VERDICT_LEAF;
        end else if (lvl_i == ptw_pkg::LVL3) begin
            // no table below the last level
            verdict_o = ptw_pkg::VERDICT_FAULT;
        end else begin
            verdict_o = ptw_pkg::VERDICT_NEXT;
        end
    end

endmodule

/* src/ptw_top.sv */
// Sv39 page table walker top level with context, entry checker and walk FSM
`timescale 1ns/1ps

module ptw_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                enable_translation_i,
    input  logic                en_ld_st_translation_i,
    input  logic                lsu_is_store_i,
    input  logic                mxr_i,
    input  ptw_pkg::asid_t      asid_i,
    input  ptw_pkg::ppn_t       satp_ppn_i,
    input  logic                itlb_access_i,
    input  logic                itlb_hit_i,
    input  ptw_pkg::vaddr_t     itlb_vaddr_i,
    input  logic                dtlb_access_i,
    input  logic                dtlb_hit_i,
    input  ptw_pkg::vaddr_t     dtlb_vaddr_i,
    input  ptw_pkg::mem_rsp_t   mem_rsp_i,
    output ptw_pkg::mem_req_t   mem_req_o,
    output logic                itlb_update_valid_o,
    output logic                dtlb_update_valid_o,
    output ptw_pkg::tlb_entry_t update_entry_o,
    output ptw_pkg::vaddr_t     update_vaddr_o,
    output logic                ptw_active_o,
    output logic                walking_instr_o,
    output logic                ptw_error_o
);

    ptw_pkg::ctx_ctl_t     ctl;
    ptw_pkg::walk_lvl_e    lvl;
    ptw_pkg::pte_t         pte;
    ptw_pkg::pte_verdict_e verdict;
    ptw_pkg::paddr_t       pptr;
    logic                  is_instr;
    logic                  rsp_valid;
    logic                  req;

    // ----------------------------------------
    // read port
    // ----------------------------------------
    assign mem_req_o.req  = req;
    assign mem_req_o.addr = pptr;

    assign walking_instr_o = is_instr;

    ptw_walk_ctx i_walk_ctx (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ctl_i        (ctl),
        .itlb_vaddr_i (itlb_vaddr_i),
        .dtlb_vaddr_i (dtlb_vaddr_i),
        .asid_i       (asid_i),
        .satp_ppn_i   (satp_ppn_i),
        .pte_i        (pte),
        .pptr_o       (pptr),
        .lvl_o        (lvl),
        .is_instr_o   (is_instr),
        .vaddr_o      (update_vaddr_o),
        .entry_o      (update_entry_o)
    );

    ptw_pte_check i_pte_check (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .mem_rsp_i      (mem_rsp_i),
        .lvl_i          (lvl),
        .is_instr_i     (is_instr),
        .mxr_i          (mxr_i),
        .lsu_is_store_i (lsu_is_store_i),
        .rsp_valid_o    (rsp_valid),
        .pte_o          (pte),
        .verdict_o      (verdict)
    );

    ptw_fsm i_fsm (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .flush_i                (flush_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .mem_gnt_i              (mem_rsp_i.gnt),
        .rsp_valid_i            (rsp_valid),
        .verdict_i              (verdict),
        .is_instr_i             (is_instr),
        .ctl_o                  (ctl),
        .mem_req_o              (req),
        .itlb_update_valid_o    (itlb_update_valid_o),
        .dtlb_update_valid_o    (dtlb_update_valid_o),
        .ptw_active_o           (ptw_active_o),
        .ptw_error_o            (ptw_error_o)
    );

endmodule

/* src/ptw_walk_ctx.sv */
// walk-context registers and TLB update entry assembly
`timescale 1ns/1ps

module ptw_walk_ctx (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  ptw_pkg::ctx_ctl_t   ctl_i,
    input  ptw_pkg::vaddr_t     itlb_vaddr_i,
    input  ptw_pkg::vaddr_t     dtlb_vaddr_i,
    input  ptw_pkg::asid_t      asid_i,
    input  ptw_pkg::ppn_t       satp_ppn_i,
    input  ptw_pkg::pte_t       pte_i,
    output ptw_pkg::paddr_t     pptr_o,
    output ptw_pkg::walk_lvl_e  lvl_o,
    output logic                is_instr_o,
    output ptw_pkg::vaddr_t     vaddr_o,
    output ptw_pkg::tlb_entry_t entry_o
);

    // page offset sits below the VPN
    localparam int OFFS = ptw_pkg::VLEN - ptw_pkg::VPNW;

    ptw_pkg::vaddr_t    vaddr_q;
    ptw_pkg::asid_t     asid_q;
    ptw_pkg::paddr_t    pptr_q;
    ptw_pkg::walk_lvl_e lvl_q;
    logic               is_instr_q;
    logic               global_q;

    // address of the missing side for a start
    ptw_pkg::vaddr_t start_vaddr;
    // VPN slice that indexes the next table
    logic [ptw_pkg::LVL_BITS-1:0] next_slice;

    assign start_vaddr = ctl_i.start_instr ? itlb_vaddr_i : dtlb_vaddr_i;

    always_comb begin
        // LVL1 -> VPN[1], LVL2 -> VPN[0]
        if (lvl_q == ptw_pkg::LVL1) begin
            next_slice = vaddr_q[OFFS + ptw_pkg::LVL_BITS +: ptw_pkg::LVL_BITS];
        end else begin
            next_slice = vaddr_q[OFFS +: ptw_pkg::LVL_BITS];
        end
    end

    // ----------------------------------------
    // control state
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lvl_q      <= ptw_pkg::LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
        end else if (ctl_i.start) begin
            lvl_q      <= ptw_pkg::LVL1;
            is_instr_q <= ctl_i.start_instr;
            global_q   <= 1'b0;
        end else begin
            // g on any level makes the whole mapping global
            if (ctl_i.note_pte) begin
                global_q <= global_q | pte_i.g;
            end
            if (ctl_i.descend) begin
                lvl_q <= (lvl_q == ptw_pkg::LVL1) ? ptw_pkg::LVL2 : ptw_pkg::LVL3;
            end
        end
    end

    // ----------------------------------------
    // payload registers for address, ASID and table pointer
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (ctl_i.start) begin
            vaddr_q <= start_vaddr;
            asid_q  <= asid_i;
            // root table from satp indexed by VPN[2]
            pptr_q  <= {satp_ppn_i,
                        start_vaddr[OFFS + 2*ptw_pkg::LVL_BITS +: ptw_pkg::LVL_BITS],
                        {ptw_pkg::PTE_BYTES_LOG{1'b0}}};
        end else if (ctl_i.descend) begin
            pptr_q <= {pte_i.ppn, next_slice, {ptw_pkg::PTE_BYTES_LOG{1'b0}}};
        end
    end

    assign pptr_o     = pptr_q;
    assign lvl_o      = lvl_q;
    assign is_instr_o = is_instr_q;
    assign vaddr_o    = vaddr_q;

    // update entry is valid only while the FSM pulses an update
    always_comb begin
        entry_o.vpn       = vaddr_q[ptw_pkg::VLEN-1 -: ptw_pkg::VPNW];
        entry_o.asid      = asid_q;
        entry_o.is_1g     = (lvl_q == ptw_pkg::LVL1);
        entry_o.is_2m     = (lvl_q == ptw_pkg::LVL2);
        entry_o.content   = pte_i;
        // include the leaf's own g bit
        entry_o.content.g = pte_i.g | global_q;
    end

endmodule

/* verification/ptw_assert.sv */
// concurrent checks on the walk FSM handshake and pulse outputs, bound into ptw_fsm
`timescale 1ns/1ps

module ptw_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic mem_gnt_i,
    input logic mem_req_o,
    input logic itlb_update_valid_o,
    input logic dtlb_update_valid_o,
    input logic ptw_error_o
);

    // request is held until granted, a flush may drop it
    req_held_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i && !flush_i) |=> mem_req_o)
        else $error("read request dropped without a grant");

    // a walk ends either with an update or with an error
    update_error_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !((itlb_update_valid_o || dtlb_update_valid_o) && ptw_error_o))
        else $error("update and error pulse in the same cycle");

    update_one_side: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_update_valid_o && dtlb_update_valid_o))
        else $error("ITLB and DTLB updates in the same cycle");

    // quiet outputs while reset is held
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !(itlb_update_valid_o || dtlb_update_valid_o || ptw_error_o || mem_req_o))
        else $error("pulse output high during reset");

endmodule

bind ptw_fsm ptw_assert u_fsm_assert (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .mem_gnt_i           (mem_gnt_i),
    .mem_req_o           (mem_req_o),
    .itlb_update_valid_o (itlb_update_valid_o),
    .dtlb_update_valid_o (dtlb_update_valid_o),
    .ptw_error_o         (ptw_error_o)
);

/* verification/ptw_tb.sv */
// ptw_top testbench with clock, reset, page table memory model, stimulus table, checks, watchdog
`timescale 1ns/1ps

module ptw_tb;

    localparam int NROWS      = 18;
    // observation window per row in cycles
    localparam int ROW_CYCLES = 40;
    localparam ptw_pkg::ppn_t ROOT_PPN = 44'h100;

    // outcome codes
    localparam logic [1:0] OUT_NONE   = 2'd0;
    localparam logic [1:0] OUT_UPDATE = 2'd1;
    localparam logic [1:0] OUT_ERROR  = 2'd2;

    // side is 0 for data, 1 for instruction and 2 for both misses at once
    typedef struct packed {
        logic [1:0]      side;
        ptw_pkg::vaddr_t va;
        logic            store;
        logic            mxr;
        logic            en;
        logic [3:0]      flush_cyc;
        logic [1:0]      outcome;
        ptw_pkg::ppn_t   ppn;
        logic            is_1g;
        logic            is_2m;
        logic            g;
    } row_t;

    logic                clk_i;
    logic                rst_ni;
    logic                flush_i;
    logic                enable_translation_i;
    logic                en_ld_st_translation_i;
    logic                lsu_is_store_i;
    logic                mxr_i;
    ptw_pkg::asid_t      asid_i;
    ptw_pkg::ppn_t       satp_ppn_i;
    logic                itlb_access_i;
    logic                itlb_hit_i;
    ptw_pkg::vaddr_t     itlb_vaddr_i;
    logic                dtlb_access_i;
    logic                dtlb_hit_i;
    ptw_pkg::vaddr_t     dtlb_vaddr_i;
    ptw_pkg::mem_rsp_t   mem_rsp;
    ptw_pkg::mem_req_t   mem_req;
    logic                itlb_update_valid_o;
    logic                dtlb_update_valid_o;
    ptw_pkg::tlb_entry_t update_entry_o;
    ptw_pkg::vaddr_t     update_vaddr_o;
    logic                ptw_active_o;
    logic                walking_instr_o;
    logic                ptw_error_o;

    logic [63:0] pt_mem [ptw_pkg::paddr_t];
    row_t        rows [NROWS];
    int unsigned lcg_state = 65;
    int          errors = 0;
    int          rows_failed = 0;

    ptw_top UUT (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .flush_i                (flush_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .mxr_i                  (mxr_i),
        .asid_i                 (asid_i),
        .satp_ppn_i             (satp_ppn_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vaddr_i           (itlb_vaddr_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vaddr_i           (dtlb_vaddr_i),
        .mem_rsp_i              (mem_rsp),
        .mem_req_o              (mem_req),
        .itlb_update_valid_o    (itlb_update_valid_o),
        .dtlb_update_valid_o    (dtlb_update_valid_o),
        .update_entry_o         (update_entry_o),
        .update_vaddr_o         (update_vaddr_o),
        .ptw_active_o           (ptw_active_o),
        .walking_instr_o        (walking_instr_o),
        .ptw_error_o            (ptw_error_o)
    );

    always #4 clk_i = ~clk_i;

    function int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function ptw_pkg::vaddr_t va_of(input int v2, input int v1, input int v0);
        return {9'(v2), 9'(v1), 9'(v0), 12'h000};
    endfunction

    // address of entry idx in the table at ppn
    function ptw_pkg::paddr_t slot(input ptw_pkg::ppn_t ppn, input int idx);
        return {ppn, 9'(idx), 3'b000};
    endfunction

    // flags are d a g u x w r v
    function logic [63:0] pte_word(input ptw_pkg::ppn_t ppn, input logic [7:0] flags);
        return {10'b0, ppn, 2'b00, flags};
    endfunction

    function row_t mk_row(input logic [1:0] side, input ptw_pkg::vaddr_t va, input logic store,
                          input logic mxr, input logic en, input logic [3:0] flush_cyc,
                          input logic [1:0] outcome, input ptw_pkg::ppn_t ppn,
                          input logic is_1g, input logic is_2m, input logic g);
        return '{side, va, store, mxr, en, flush_cyc, outcome, ppn, is_1g, is_2m, g};
    endfunction

    // ----------------------------------------
    // page tables
    // ----------------------------------------
    task automatic build_tables();
        // root holds a global pointer, two 1G leaves and an empty slot 3
        pt_mem[slot(ROOT_PPN, 0)] = pte_word(44'h200, 8'h21);
        pt_mem[slot(ROOT_PPN, 1)] = pte_word(44'h40000, 8'hCF);
        pt_mem[slot(ROOT_PPN, 2)] = pte_word(44'h40001, 8'hCF);
        // second level holds a pointer and aligned and misaligned 2M leaves
        pt_mem[slot(44'h200, 0)] = pte_word(44'h210, 8'h01);
        pt_mem[slot(44'h200, 1)] = pte_word(44'h1200, 8'hCF);
        pt_mem[slot(44'h200, 2)] = pte_word(44'h1201, 8'hCF);
        // last level with one permission case per slot
        pt_mem[slot(44'h210, 0)] = pte_word(44'hABCDE, 8'hCF);
        pt_mem[slot(44'h210, 1)] = pte_word(44'h11, 8'hC3);
        pt_mem[slot(44'h210, 2)] = pte_word(44'h22, 8'h8F);
        pt_mem[slot(44'h210, 3)] = pte_word(44'h33, 8'h47);
        pt_mem[slot(44'h210, 4)] = pte_word(44'h44, 8'h49);
        pt_mem[slot(44'h210, 5)] = pte_word(44'h55, 8'h01);
        pt_mem[slot(44'h210, 6)] = pte_word(44'h66, 8'h4B);
    endtask

    task automatic build_rows();
        rows[0]  = mk_row(2'd0, va_of(0, 0, 0), 0, 0, 1, 0, OUT_UPDATE, 44'hABCDE, 0, 0, 1);
        rows[1]  = mk_row(2'd0, va_of(1, 0, 0), 0, 0, 1, 0, OUT_UPDATE, 44'h40000, 1, 0, 0);
        rows[2]  = mk_row(2'd0, va_of(2, 0, 0), 0, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[3]  = mk_row(2'd0, va_of(0, 1, 0), 0, 0, 1, 0, OUT_UPDATE, 44'h1200, 0, 1, 1);
        rows[4]  = mk_row(2'd0, va_of(0, 2, 0), 0, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[5]  = mk_row(2'd1, va_of(0, 0, 1), 0, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[6]  = mk_row(2'd0, va_of(0, 0, 2), 0, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[7]  = mk_row(2'd0, va_of(0, 0, 3), 1, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[8]  = mk_row(2'd0, va_of(0, 0, 4), 0, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[9]  = mk_row(2'd0, va_of(0, 0, 4), 0, 1, 1, 0, OUT_UPDATE, 44'h44, 0, 0, 1);
        rows[10] = mk_row(2'd0, va_of(3, 0, 0), 0, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[11] = mk_row(2'd0, va_of(0, 0, 5), 0, 0, 1, 0, OUT_ERROR, '0, 0, 0, 0);
        rows[12] = mk_row(2'd2, va_of(0, 0, 0), 0, 0, 1, 0, OUT_UPDATE, 44'hABCDE, 0, 0, 1);
        rows[13] = mk_row(2'd1, va_of(0, 0, 6), 0, 0, 1, 0, OUT_UPDATE, 44'h66, 0, 0, 1);
        rows[14] = mk_row(2'd0, va_of(0, 0, 0), 0, 0, 1, 3, OUT_NONE, '0, 0, 0, 0);
        rows[15] = mk_row(2'd0, va_of(0, 0, 0), 1, 0, 1, 0, OUT_UPDATE, 44'hABCDE, 0, 0, 1);
        rows[16] = mk_row(2'd0, va_of(0, 0, 0), 0, 0, 0, 0, OUT_NONE, '0, 0, 0, 0);
        rows[17] = mk_row(2'd1, va_of(0, 0, 6), 0, 0, 0, 0, OUT_NONE, '0, 0, 0, 0);
    endtask

    // ----------------------------------------
    // read port model
    // ----------------------------------------
    always begin
        int gnt_wait;
        int rv_wait;
        ptw_pkg::paddr_t addr;
        @(posedge clk_i);
        #1;
        if (mem_req.req) begin
            gnt_wait = int'(lcg_next() % 4);
            rv_wait  = 1 + int'(lcg_next() % 2);
            repeat (gnt_wait) begin
                @(posedge clk_i);
                #1;
            end
            // a flush can withdraw the request before the grant
            if (mem_req.req) begin
                addr        = mem_req.addr;
                mem_rsp.gnt = 1'b1;
                @(posedge clk_i);
                #1;
                mem_rsp.gnt = 1'b0;
                if (rv_wait == 2) begin
                    @(posedge clk_i);
                    #1;
                end
                mem_rsp.rvalid = 1'b1;
                mem_rsp.rdata  = pt_mem.exists(addr) ? pt_mem[addr] : 64'h0;
                @(posedge clk_i);
                #1;
                mem_rsp.rvalid = 1'b0;
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp)
        else begin
            $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic expect_true(input int idx, input logic cond, input string what);
        assert (cond)
        else begin
            $display("row %0d: %s", idx, what);
            errors++;
        end
    endtask

    // entry and side seen during an update pulse
    task automatic check_entry(input row_t r);
        logic instr;
        instr = (r.side == 2'd1);
        check_val("itlb_update_valid_o", 64'(instr), 64'(itlb_update_valid_o));
        check_val("dtlb_update_valid_o", 64'(!instr), 64'(dtlb_update_valid_o));
        check_val("walking_instr_o", 64'(instr), 64'(walking_instr_o));
        check_val("update_vaddr_o", 64'(r.va), 64'(update_vaddr_o));
        check_val("update_entry_o.vpn", 64'(r.va[38:12]), 64'(update_entry_o.vpn));
        check_val("update_entry_o.asid", 64'(asid_i), 64'(update_entry_o.asid));
        check_val("update_entry_o.ppn", 64'(r.ppn), 64'(update_entry_o.content.ppn));
        check_val("update_entry_o.is_1g", 64'(r.is_1g), 64'(update_entry_o.is_1g));
        check_val("update_entry_o.is_2m", 64'(r.is_2m), 64'(update_entry_o.is_2m));
        check_val("update_entry_o.g", 64'(r.g), 64'(update_entry_o.content.g));
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   cyc;
        int   errs_before;
        int   n_upd;
        int   n_err;
        logic seen_active;
        logic seen_req;
        r           = rows[idx];
        errs_before = errors;
        n_upd       = 0;
        n_err       = 0;
        seen_active = 1'b0;
        seen_req    = 1'b0;
        cyc         = 0;
        @(posedge clk_i);
        #1;
        asid_i                 = 16'h0100 + 16'(idx);
        mxr_i                  = r.mxr;
        lsu_is_store_i         = r.store;
        // only the enable of the missing side follows the row
        enable_translation_i   = r.en || (r.side == 2'd0);
        en_ld_st_translation_i = r.en || (r.side == 2'd1);
        dtlb_vaddr_i           = r.va;
        itlb_vaddr_i           = (r.side == 2'd2) ? va_of(0, 0, 6) : r.va;
        dtlb_access_i          = (r.side != 2'd1);
        itlb_access_i          = (r.side != 2'd0);
        while (cyc < ROW_CYCLES) begin
            // sample mid-cycle where outputs are settled
            @(negedge clk_i);
            if (itlb_update_valid_o || dtlb_update_valid_o) begin
                n_upd++;
                check_entry(r);
            end
            if (ptw_error_o) begin
                n_err++;
            end
            seen_active = seen_active | ptw_active_o;
            seen_req    = seen_req | mem_req.req;
            @(posedge clk_i);
            #1;
            itlb_access_i = 1'b0;
            dtlb_access_i = 1'b0;
            flush_i       = (r.flush_cyc != 4'd0) && (cyc + 1 == int'(r.flush_cyc));
            cyc++;
            if ((n_upd != 0 || n_err != 0) && !ptw_active_o) begin
                break;
            end
        end
        flush_i = 1'b0;
        case (r.outcome)
            OUT_UPDATE: expect_true(idx, n_upd == 1 && n_err == 0, "no single clean update pulse");
            OUT_ERROR:  expect_true(idx, n_err == 1 && n_upd == 0, "no single clean error pulse");
            default:    expect_true(idx, n_upd == 0 && n_err == 0, "unexpected pulse");
        endcase
        if (r.outcome != OUT_NONE && n_upd == 0 && n_err == 0) begin
            $display("row %0d: walk timed out after %0d cycles", idx, ROW_CYCLES);
        end
        expect_true(idx, !ptw_active_o, "walker still active at end of row");
        if (r.flush_cyc != 4'd0) begin
            expect_true(idx, seen_active, "walker never started before the flush");
        end
        if (!r.en) begin
            expect_true(idx, !seen_active, "walker started with translation disabled");
            expect_true(idx, !seen_req, "read request with translation disabled");
        end
        if (errors == errs_before) begin
            $display("row %0d passed", idx);
        end else begin
            $display("row %0d failed", idx);
            rows_failed++;
        end
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        repeat (NROWS * 60 + 8) @(posedge clk_i);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk_i                  = 1'b0;
        rst_ni                 = 1'b0;
        flush_i                = 1'b0;
        enable_translation_i   = 1'b0;
        en_ld_st_translation_i = 1'b0;
        lsu_is_store_i         = 1'b0;
        mxr_i                  = 1'b0;
        asid_i                 = '0;
        satp_ppn_i             = ROOT_PPN;
        itlb_access_i          = 1'b0;
        itlb_hit_i             = 1'b0;
        itlb_vaddr_i           = '0;
        dtlb_access_i          = 1'b0;
        dtlb_hit_i             = 1'b0;
        dtlb_vaddr_i           = '0;
        mem_rsp                = '0;
        build_tables();
        build_rows();
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end
        $display("%0d rows, %0d passed, %0d failed, %0d check errors",
                 NROWS, NROWS - rows_failed, rows_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
